// ==== design/dmem_pkg.sv ====
package dmem_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int XLEN = 32;  // Data path
  localparam int PLEN = 32;  // Physical address

  ////////////////////
  // PMA region table
  ////////////////////

  localparam int PMA_CNT   = 4;  // Number of regions
  localparam int PMA_CFG_W = 3;  // Config bits per region

  // Bit positions in one region config word
  localparam int PMA_CFG_R    = 0;  // Readable
  localparam int PMA_CFG_W_EN = 1;  // Writable
  localparam int PMA_CFG_MA   = 2;  // Misaligned access allowed

  // Transfer size codes, as on the BIU
  localparam logic [2:0] SIZE_BYTE = 3'd0;
  localparam logic [2:0] SIZE_HALF = 3'd1;
  localparam logic [2:0] SIZE_WORD = 3'd2;

  localparam int BUF_DEPTH = 2;  // Request buffer entries

  // Controller sequencer
  typedef enum logic [1:0] {
    IDLE,      // Waiting for a buffered request
    BUS_ADR,   // Strobe out on the BIU
    BUS_DATA,  // Waiting for data acknowledge or error
    RESP       // Faulted response to the CPU
  } dmem_state_t;

endpackage

// ==== design/dmem_reqbuf.sv ====
`timescale 1ns/1ps

module dmem_reqbuf
  import dmem_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            clr_i,   // Flush on exception
  input  logic            push_i,
  input  logic [PLEN-1:0] adr_i,
  input  logic [2:0]      size_i,
  input  logic            we_i,
  input  logic [XLEN-1:0] d_i,
  input  logic            pop_i,
  output logic            valid_o,
  output logic            full_o,
  output logic [PLEN-1:0] adr_o,
  output logic [2:0]      size_o,
  output logic            we_o,
  output logic [XLEN-1:0] d_o
);

  // Entry storage
  logic [PLEN-1:0] adr_mem  [BUF_DEPTH];
  logic [2:0]      size_mem [BUF_DEPTH];
  logic            we_mem   [BUF_DEPTH];
  logic [XLEN-1:0] d_mem    [BUF_DEPTH];

  logic [$clog2(BUF_DEPTH)-1:0]   wr_ptr, rd_ptr;
  logic [$clog2(BUF_DEPTH+1)-1:0] cnt;
  logic                           do_push, do_pop;

  assign do_push = push_i & ~full_o;   // Top already gates with grant
  assign do_pop  = pop_i & valid_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      adr_mem[wr_ptr]  <= adr_i;
      size_mem[wr_ptr] <= size_i;
      we_mem[wr_ptr]   <= we_i;
      d_mem[wr_ptr]    <= d_i;
    end
  end

  // Pointers and fill level
  always_ff @(posedge clk_i) begin
    if (rst_i || clr_i) begin  // Clear beats a push in the same cycle
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      cnt <= cnt + do_push - do_pop;  // Push and pop together keep the level
    end
  end

  assign valid_o = (cnt != '0);
  assign full_o  = (cnt == BUF_DEPTH);

  // Head of queue
  assign adr_o  = adr_mem[rd_ptr];
  assign size_o = size_mem[rd_ptr];
  assign we_o   = we_mem[rd_ptr];
  assign d_o    = d_mem[rd_ptr];

endmodule

// ==== design/dmem_access_chk.sv ====
`timescale 1ns/1ps

module dmem_access_chk
  import dmem_pkg::*;
(
  input  logic [PLEN-1:0]                     adr_i,
  input  logic [2:0]                          size_i,
  input  logic                                we_i,
  input  logic [PMA_CNT-1:0][PMA_CFG_W-1:0]   pma_cfg_i,
  input  logic [PMA_CNT-1:0][PLEN-1:0]        pma_adr_i,
  output logic                                misaligned_o,
  output logic                                pma_fault_o
);

  logic                 hit;       // Some region already covers the address
  logic [PMA_CFG_W-1:0] cfg;       // Config of the winning region
  logic [PLEN-1:0]      base;      // Bottom of the region under test
  logic                 off_size;  // Address not a multiple of the size

  ////////////////////
  // Region lookup
  ////////////////////

  // Top-of-range table, region i starts where region i-1 ends
  always_comb begin
    hit  = 1'b0;
    cfg  = '0;
    base = '0;
    for (int i = 0; i < PMA_CNT; i++) begin
      if (!hit && adr_i >= base && adr_i < pma_adr_i[i]) begin  // Lowest index wins
        hit = 1'b1;
        cfg = pma_cfg_i[i];
      end
      base = pma_adr_i[i];
    end
  end

  // No match leaves cfg at zero, which denies both directions
  assign pma_fault_o = we_i ? ~cfg[PMA_CFG_W_EN] : ~cfg[PMA_CFG_R];

  ////////////////////
  // Alignment
  ////////////////////

  always_comb begin
    case (size_i)
      SIZE_HALF: off_size = adr_i[0];
      SIZE_WORD: off_size = |adr_i[1:0];
      default:   off_size = 1'b0;  // Bytes never misalign
    endcase
  end

  assign misaligned_o = off_size & ~cfg[PMA_CFG_MA];  // Region may allow it

endmodule

// ==== design/dmem_busif.sv ====
`timescale 1ns/1ps

module dmem_busif
  import dmem_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            start_i,
  input  logic [PLEN-1:0] adr_i,
  input  logic [2:0]      size_i,
  input  logic            we_i,
  input  logic [XLEN-1:0] d_i,
  input  logic            biu_stb_ack_i,
  input  logic            biu_ack_i,
  input  logic            biu_err_i,
  input  logic [XLEN-1:0] biu_q_i,
  output logic            busy_o,
  output logic            done_o,
  output logic            err_o,
  output logic [XLEN-1:0] q_o,
  output logic            biu_stb_o,
  output logic [PLEN-1:0] biu_adr_o,
  output logic [2:0]      biu_size_o,
  output logic            biu_we_o,
  output logic [XLEN-1:0] biu_d_o
);

  logic wait_data;  // Address phase taken, data still outstanding
  logic data_ph;    // Slave may answer in this cycle
  logic fin;        // Transfer ends this cycle

  assign data_ph = (biu_stb_o & biu_stb_ack_i) | wait_data;
  assign fin     = data_ph & (biu_ack_i | biu_err_i);

  ////////////////////
  // Address phase
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (start_i && !busy_o) begin  // Latch the request for the whole transfer
      biu_adr_o  <= adr_i;
      biu_size_o <= size_i;
      biu_we_o   <= we_i;
      biu_d_o    <= d_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      biu_stb_o <= 1'b0;
      wait_data <= 1'b0;
      busy_o    <= 1'b0;
    end else begin
      if (start_i && !busy_o) begin
        biu_stb_o <= 1'b1;
        busy_o    <= 1'b1;
      end else if (biu_stb_o && biu_stb_ack_i) begin
        biu_stb_o <= 1'b0;  // Strobe held until taken
      end
      // Slave answered the address but not the data yet
      if (biu_stb_o && biu_stb_ack_i && !fin) wait_data <= 1'b1;
      else if (fin)                           wait_data <= 1'b0;
      if (fin) busy_o <= 1'b0;
    end
  end

  ////////////////////
  // Data phase
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      done_o <= 1'b0;
      err_o  <= 1'b0;
    end else begin
      done_o <= fin;              // One-cycle pulse
      err_o  <= fin & biu_err_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fin && biu_ack_i) q_o <= biu_q_i;  // Read data on data acknowledge
  end

endmodule

// ==== design/dmem_ctrl.sv ====
`timescale 1ns/1ps

module dmem_ctrl
  import dmem_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            head_valid_i,
  input  logic            misaligned_i,
  input  logic            pma_fault_i,
  input  logic            bus_done_i,
  input  logic            bus_err_i,
  input  logic [XLEN-1:0] bus_q_i,
  input  logic            head_we_i,
  output logic            pop_o,
  output logic            clr_o,
  output logic            bus_start_o,
  output logic            mem_ack_o,
  output logic            mem_err_o,
  output logic            mem_misaligned_o,
  output logic [XLEN-1:0] mem_q_o
);

  dmem_state_t state, state_nxt;

  logic fault;     // Head fails alignment or PMA
  logic mis_r;     // Fault cause kept for RESP
  logic bus_resp;  // Bus transfer finishes this cycle

  assign fault = misaligned_i | pma_fault_i;

  ////////////////////
  // Sequencer
  ////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:     if (head_valid_i) state_nxt = fault ? RESP : BUS_ADR;
      BUS_ADR:  state_nxt = BUS_DATA;                 // Strobe goes out
      BUS_DATA: if (bus_done_i) state_nxt = IDLE;     // Response goes back now
      RESP:     state_nxt = IDLE;                     // Single cycle
      default:  state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) state <= IDLE;
    else       state <= state_nxt;
  end

  always_ff @(posedge clk_i) begin
    if (state == IDLE && head_valid_i) mis_r <= misaligned_i;
  end

  // Clean head goes straight to the bus, busif registers it
  assign bus_start_o = (state == IDLE) & head_valid_i & ~fault;

  ////////////////////
  // CPU response
  ////////////////////

  assign bus_resp = (state == BUS_DATA) & bus_done_i;

  assign mem_ack_o        = (state == RESP) | bus_resp;
  assign mem_err_o        = (state == RESP) | (bus_resp & bus_err_i);  // RESP is faults only
  assign mem_misaligned_o = (state == RESP) & mis_r;

  // Read data only for a clean load, zero otherwise
  assign mem_q_o = (bus_resp && !head_we_i && !bus_err_i) ? bus_q_i : '0;

  assign pop_o = mem_ack_o;   // Head retires with its acknowledge
  assign clr_o = mem_err_o;   // Any error drops what is queued behind

endmodule

// ==== design/dmem_top.sv ====
`timescale 1ns/1ps

module dmem_top
  import dmem_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              rst_i,
  // CPU side
  input  logic                              mem_req_i,
  input  logic [PLEN-1:0]                   mem_adr_i,
  input  logic [2:0]                        mem_size_i,
  input  logic                              mem_we_i,
  input  logic [XLEN-1:0]                   mem_d_i,
  output logic                              mem_gnt_o,
  output logic                              mem_ack_o,
  output logic                              mem_err_o,
  output logic                              mem_misaligned_o,
  output logic [XLEN-1:0]                   mem_q_o,
  // PMA table
  input  logic [PMA_CNT-1:0][PMA_CFG_W-1:0] pma_cfg_i,
  input  logic [PMA_CNT-1:0][PLEN-1:0]      pma_adr_i,
  // BIU
  output logic                              biu_stb_o,
  input  logic                              biu_stb_ack_i,
  output logic [PLEN-1:0]                   biu_adr_o,
  output logic [2:0]                        biu_size_o,
  output logic                              biu_we_o,
  output logic [XLEN-1:0]                   biu_d_o,
  input  logic [XLEN-1:0]                   biu_q_i,
  input  logic                              biu_ack_i,
  input  logic                              biu_err_i
);

  // Buffer head
  logic            head_valid, buf_full;
  logic [PLEN-1:0] head_adr;
  logic [2:0]      head_size;
  logic            head_we;
  logic [XLEN-1:0] head_d;

  logic            misaligned, pma_fault;
  logic            pop, clr, bus_start;
  logic            bus_done, bus_err;
  logic [XLEN-1:0] bus_q;

  assign mem_gnt_o = ~buf_full;  // Accept while there is room

  dmem_reqbuf u_reqbuf (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .clr_i   (clr),
    .push_i  (mem_req_i & mem_gnt_o),
    .adr_i   (mem_adr_i),
    .size_i  (mem_size_i),
    .we_i    (mem_we_i),
    .d_i     (mem_d_i),
    .pop_i   (pop),
    .valid_o (head_valid),
    .full_o  (buf_full),
    .adr_o   (head_adr),
    .size_o  (head_size),
    .we_o    (head_we),
    .d_o     (head_d)
  );

  dmem_access_chk u_access_chk (
    .adr_i        (head_adr),
    .size_i       (head_size),
    .we_i         (head_we),
    .pma_cfg_i    (pma_cfg_i),
    .pma_adr_i    (pma_adr_i),
    .misaligned_o (misaligned),
    .pma_fault_o  (pma_fault)
  );

  dmem_ctrl u_ctrl (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .head_valid_i     (head_valid),
    .misaligned_i     (misaligned),
    .pma_fault_i      (pma_fault),
    .bus_done_i       (bus_done),
    .bus_err_i        (bus_err),
    .bus_q_i          (bus_q),
    .head_we_i        (head_we),
    .pop_o            (pop),
    .clr_o            (clr),
    .bus_start_o      (bus_start),
    .mem_ack_o        (mem_ack_o),
    .mem_err_o        (mem_err_o),
    .mem_misaligned_o (mem_misaligned_o),
    .mem_q_o          (mem_q_o)
  );

  dmem_busif u_busif (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .start_i       (bus_start),
    .adr_i         (head_adr),
    .size_i        (head_size),
    .we_i          (head_we),
    .d_i           (head_d),
    .biu_stb_ack_i (biu_stb_ack_i),
    .biu_ack_i     (biu_ack_i),
    .biu_err_i     (biu_err_i),
    .biu_q_i       (biu_q_i),
    .busy_o        (),              // Sequencer tracks the transfer itself
    .done_o        (bus_done),
    .err_o         (bus_err),
    .q_o           (bus_q),
    .biu_stb_o     (biu_stb_o),
    .biu_adr_o     (biu_adr_o),
    .biu_size_o    (biu_size_o),
    .biu_we_o      (biu_we_o),
    .biu_d_o       (biu_d_o)
  );

endmodule

// ==== test/tb_dmem.sv ====
`timescale 1ns/1ps

module tb_dmem
  import dmem_pkg::*;
();

  localparam int TIMEOUT  = 200;  // Cycles per wait
  localparam int MAX_LINE = 64;
  localparam int DRV_DLY  = 1;    // Input skew after the rising edge

  // Region configs, R/W/MA bits
  localparam logic [PMA_CFG_W-1:0] CFG_RO  = 1 << PMA_CFG_R;
  localparam logic [PMA_CFG_W-1:0] CFG_RW  = CFG_RO | (1 << PMA_CFG_W_EN);
  localparam logic [PMA_CFG_W-1:0] CFG_RWM = CFG_RW | (1 << PMA_CFG_MA);
  localparam logic [PMA_CFG_W-1:0] CFG_NA  = '0;
  localparam logic [PMA_CNT-1:0][PMA_CFG_W-1:0] PMA_CFG = {CFG_RWM, CFG_NA, CFG_RO, CFG_RW};
  localparam logic [PMA_CNT-1:0][PLEN-1:0] PMA_TOP =     // Top of each region
    {32'h0000_4000, 32'h0000_3000, 32'h0000_2000, 32'h0000_1000};

  logic clk_i, rst_i, mem_req_i, mem_we_i, mem_gnt_o, mem_ack_o, mem_err_o, mem_misaligned_o;
  logic [PLEN-1:0] mem_adr_i, biu_adr_o;
  logic [2:0]      mem_size_i, biu_size_o;
  logic [XLEN-1:0] mem_d_i, mem_q_o, biu_d_o, biu_q_i;
  logic biu_stb_o, biu_stb_ack_i, biu_we_o, biu_ack_i, biu_err_i;
  logic [PMA_CNT-1:0][PMA_CFG_W-1:0] pma_cfg_i;
  logic [PMA_CNT-1:0][PLEN-1:0]      pma_adr_i;

  // Golden columns, one entry per access
  logic            g_pair [MAX_LINE], g_we [MAX_LINE], g_berr [MAX_LINE];
  logic            g_ack [MAX_LINE], g_err [MAX_LINE], g_mis [MAX_LINE];
  logic [2:0]      g_size [MAX_LINE];
  logic [PLEN-1:0] g_adr [MAX_LINE];
  logic [XLEN-1:0] g_wd [MAX_LINE], g_rd [MAX_LINE], g_q [MAX_LINE];
  int              num_lines;
  int              bus_exp [$];        // Lines still owed a strobe
  integer          seed = 32'hae5d_3d5f;

  dmem_top dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;  // 8 ns period
  end

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic stop_run();
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at first failure");
  endtask

  task automatic check_data(input string name, input logic [XLEN-1:0] act, exp);
    if (act !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, act, exp);
      stop_run();
    end
  endtask

  task automatic check_adr(input string name, input logic [PLEN-1:0] act, exp);
    if (act !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, act, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic act, exp);
    if (act !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, act, exp);
      stop_run();
    end
  endtask

  ////////////////////
  // CPU side
  ////////////////////

  task automatic load_golden();
    int fd;
    logic [8*160-1:0] line;
    fd = $fopen("test/dmem_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open test/dmem_golden.txt");
      stop_run();
    end
    num_lines = 0;
    while ($fgets(line, fd) != 0) begin
      // Comment lines fail the scan and are skipped
      if ($sscanf(line, "%d %d %d %h %h %h %d %d %d %d %h", g_pair[num_lines],
          g_we[num_lines], g_size[num_lines], g_adr[num_lines], g_wd[num_lines],
          g_rd[num_lines], g_berr[num_lines], g_ack[num_lines], g_err[num_lines],
          g_mis[num_lines], g_q[num_lines]) == 11)
        num_lines++;
    end
    $fclose(fd);
    if (num_lines == 0) begin
      $display("No access lines found in test/dmem_golden.txt");
      stop_run();
    end
  endtask

  task automatic drive_req(input int i);
    mem_req_i  = 1'b1;
    mem_adr_i  = g_adr[i];
    mem_size_i = g_size[i];
    mem_we_i   = g_we[i];
    mem_d_i    = g_wd[i];
    if (g_ack[i] && (!g_err[i] || g_berr[i])) bus_exp.push_back(i);  // Reaches the bus
  endtask

  task automatic wait_grant(input int i);
    int cyc;
    cyc = 0;
    @(negedge clk_i);
    while (!mem_gnt_o && cyc < TIMEOUT) begin
      cyc++;
      @(negedge clk_i);
    end
    if (!mem_gnt_o) begin
      $display("Timeout waiting for mem_gnt_o on line %0d", i);
      stop_run();
    end
    @(posedge clk_i);  // Accepted here
  endtask

  task automatic wait_ack(input int i);
    int cyc;
    dmem_state_t st;
    cyc = 0;
    @(negedge clk_i);
    while (!mem_ack_o && cyc < TIMEOUT) begin
      cyc++;
      @(negedge clk_i);
    end
    if (!mem_ack_o) begin
      st = dut0.u_ctrl.state;
      $display("Timeout waiting for mem_ack_o on line %0d in state %s", i, st.name());
      stop_run();
    end
    check_flag("mem_err_o", mem_err_o, g_err[i]);
    check_flag("mem_misaligned_o", mem_misaligned_o, g_mis[i]);
    check_data("mem_q_o", mem_q_o, g_q[i]);
    @(negedge clk_i);
    check_flag("mem_ack_o", mem_ack_o, 1'b0);  // One-cycle pulse
  endtask

  task automatic expect_no_ack(input int i);
    repeat (TIMEOUT) begin
      @(negedge clk_i);
      if (mem_ack_o) begin
        $display("Dropped request of line %0d was acknowledged", i);
        stop_run();
      end
    end
  endtask

  ////////////////////
  // BIU slave model
  ////////////////////

  initial begin : biu_responder
    int idx, d_adr, d_data;
    forever begin
      @(negedge clk_i);
      if (biu_stb_o) begin
        if (bus_exp.size() == 0) begin
          $display("Unexpected BIU strobe to address %h", biu_adr_o);
          stop_run();
        end
        idx = bus_exp.pop_front();
        check_adr("biu_adr_o", biu_adr_o, g_adr[idx]);
        check_data("biu_size_o", XLEN'(biu_size_o), XLEN'(g_size[idx]));
        check_flag("biu_we_o", biu_we_o, g_we[idx]);
        if (g_we[idx]) check_data("biu_d_o", biu_d_o, g_wd[idx]);
        d_adr  = $unsigned($random(seed)) % 4;  // Strobe acknowledge delay
        d_data = $unsigned($random(seed)) % 2;  // Split data phase or not
        repeat (d_adr) begin
          @(negedge clk_i);
          check_flag("biu_stb_o", biu_stb_o, 1'b1);  // Held until taken
        end
        @(posedge clk_i);
        #DRV_DLY biu_stb_ack_i = 1'b1;
        if (d_data != 0) begin
          @(posedge clk_i);
          #DRV_DLY biu_stb_ack_i = 1'b0;
        end
        biu_ack_i = ~g_berr[idx];
        biu_err_i = g_berr[idx];
        // Stores see nonzero junk that mem_q_o has to mask
        biu_q_i   = g_we[idx] ? (XLEN'($random(seed)) | XLEN'(1)) : g_rd[idx];
        @(posedge clk_i);
        #DRV_DLY biu_stb_ack_i = 1'b0;
        biu_ack_i = 1'b0;
        biu_err_i = 1'b0;
        biu_q_i   = '0;
      end
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin : main_seq
    int i;
    rst_i = 1'b1;
    mem_req_i = 1'b0;
    mem_adr_i = '0;
    mem_size_i = SIZE_WORD;
    mem_we_i = 1'b0;
    mem_d_i = '0;
    biu_stb_ack_i = 1'b0;
    biu_ack_i = 1'b0;
    biu_err_i = 1'b0;
    biu_q_i = '0;
    pma_cfg_i = PMA_CFG;
    pma_adr_i = PMA_TOP;
    load_golden();
    repeat (5) @(posedge clk_i);
    #DRV_DLY rst_i = 1'b0;
    @(negedge clk_i);
    check_flag("mem_gnt_o", mem_gnt_o, 1'b1);    // Reset state
    check_flag("mem_ack_o", mem_ack_o, 1'b0);
    check_flag("mem_err_o", mem_err_o, 1'b0);
    check_flag("mem_misaligned_o", mem_misaligned_o, 1'b0);
    check_flag("biu_stb_o", biu_stb_o, 1'b0);
    i = 0;
    while (i < num_lines) begin
      @(posedge clk_i);
      #DRV_DLY drive_req(i);
      wait_grant(i);
      if (g_pair[i]) begin                       // Second request right behind
        #DRV_DLY drive_req(i + 1);
        @(negedge clk_i);
        check_flag("mem_gnt_o", mem_gnt_o, 1'b1);
        @(posedge clk_i);
      end
      #DRV_DLY mem_req_i = 1'b0;
      wait_ack(i);
      if (g_pair[i]) begin
        if (g_ack[i + 1]) wait_ack(i + 1);
        else              expect_no_ack(i + 1);
        i++;
      end
      i++;
    end
    if (bus_exp.size() != 0) begin
      $display("%0d expected BIU strobes never appeared", bus_exp.size());
      stop_run();
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== verilog.f ====
design/dmem_pkg.sv
design/dmem_reqbuf.sv
design/dmem_access_chk.sv
design/dmem_busif.sv
design/dmem_ctrl.sv
design/dmem_top.sv
test/tb_dmem.sv

// ==== Bender.yml ====
package:
  name: dmem

sources:
  - design/dmem_pkg.sv
  - design/dmem_reqbuf.sv
  - design/dmem_access_chk.sv
  - design/dmem_busif.sv
  - design/dmem_ctrl.sv
  - design/dmem_top.sv
  - target: test
    files:
      - test/tb_dmem.sv

// ==== test/dmem_golden.txt ====
# pair we size adr wdata bus_rdata bus_err | exp_ack exp_err exp_misaligned exp_q
# pair 1 issues this line and the next one back to back, all values hex except flags and size
0 0 2 00000100 00000000 12345678 0 1 0 0 12345678
0 1 2 00000104 deadbeef 00000000 0 1 0 0 00000000
0 0 1 00000202 00000000 0000beef 0 1 0 0 0000beef
0 1 0 00000303 000000aa 00000000 0 1 0 0 00000000
0 0 1 00000011 00000000 00000000 0 1 1 1 00000000
0 1 2 00000022 0000cafe 00000000 0 1 1 1 00000000
0 0 2 00003002 00000000 00001111 0 1 0 0 00001111
0 1 1 00003105 0badf00d 00000000 0 1 0 0 00000000
0 0 2 00001000 00000000 11110000 0 1 0 0 11110000
0 1 2 00001004 a5a5a5a5 00000000 0 1 1 0 00000000
0 0 2 00002000 00000000 00000000 0 1 1 0 00000000
0 1 0 00002abc 00000077 00000000 0 1 1 0 00000000
0 0 2 00004000 00000000 00000000 0 1 1 0 00000000
0 0 2 00000400 00000000 00000000 1 1 1 0 00000000
1 0 2 00000500 00000000 13572468 0 1 0 0 13572468
0 1 2 00000504 24681357 00000000 0 1 0 0 00000000
1 0 2 00002010 00000000 00000000 0 1 1 0 00000000
0 0 2 00000010 00000000 55555555 0 0 0 0 00000000
1 0 1 00000033 00000000 00000000 0 1 1 1 00000000
0 1 2 00000040 11223344 00000000 0 0 0 0 00000000
0 0 2 00000ffc 00000000 0f0f0f0f 0 1 0 0 0f0f0f0f
